/* Makefile */
# Verilator build and run of the huffman code generator testbench

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"

test:
	verilator --binary --timing --assert -f files.f --top-module huff_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vhuff_tb)"; echo "$$out"; \
	echo "$$out" | grep -q "^Test completed successfully$$"

clean:
	rm -rf obj_dir

/* design/huff_code_table.sv */
// 16 entries indexed by symbol; lookup is combinational and reads zero for an invalid entry
`timescale 1ns/1ps
`default_nettype none

module huff_code_table (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  wr_en,
    input  wire huff_pkg::code_wr_t    wr,
    input  wire logic                  clear,
    input  wire logic                  walk_done,
    input  wire huff_pkg::sym_t        lookup_sym,
    output huff_pkg::code_entry_t      lookup_entry,
    output logic                       write_finish,
    output logic                       book_ready
);

    huff_pkg::code_entry_t          tab [huff_pkg::SYM_COUNT];  // len and bits payload
    logic [huff_pkg::SYM_COUNT-1:0] valid;

    assign lookup_entry = valid[lookup_sym] ? tab[lookup_sym] : '0;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tab[wr.sym] <= wr.entry;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            valid        <= '0;
            write_finish <= 1'b0;
            book_ready   <= 1'b0;
        end else begin
            write_finish <= wr_en;  // ack one cycle after the write
            if (clear) begin
                valid      <= '0;
                book_ready <= 1'b0;
            end else begin
                if (wr_en) valid[wr.sym] <= wr.entry.valid;
                if (walk_done) book_ready <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/huff_codebook_walk.sv */
// depth-first walk, left before right; the tree must stay stable until walk_done
`timescale 1ns/1ps
`default_nettype none

module huff_codebook_walk (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 tree_done,
    input  wire huff_pkg::node_idx_t  root,
    input  wire huff_pkg::tree_node_t node,
    input  wire logic                 write_finish,
    output huff_pkg::node_idx_t       node_addr,
    output huff_pkg::code_wr_t        wr,
    output logic                      wr_en,
    output logic                      walk_done
);

    huff_pkg::walk_state_t state;
    huff_pkg::code_bits_t  path;       // moves so far, last move in bit 0
    huff_pkg::code_len_t   track_len;  // number of valid moves in path
    huff_pkg::code_len_t   pos;        // replay step in TRACK
    huff_pkg::node_idx_t   cur;        // node being looked at
    huff_pkg::node_idx_t   top;        // root of this block

    logic                 move;        // 1 on a right step
    huff_pkg::child_ref_t child;
    huff_pkg::code_bits_t next_path;
    huff_pkg::code_len_t  next_len;
    logic                 trk_bit;

    assign move      = (state == huff_pkg::RIGHT);
    assign child     = move ? node.right : node.left;
    assign next_path = {path[huff_pkg::MAX_CODE_LEN-2:0], move};
    assign next_len  = track_len + 4'd1;
    assign trk_bit   = path[track_len - pos - 4'd1];  // replay from the oldest move
    assign node_addr = cur;
    assign walk_done = (state == huff_pkg::FINISH);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state     <= huff_pkg::INIT;
            path      <= '0;
            track_len <= '0;
            pos       <= '0;
            cur       <= '0;
            top       <= '0;
            wr        <= '0;
            wr_en     <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            case (state)
                huff_pkg::INIT: begin
                    if (tree_done) begin
                        cur       <= root;
                        top       <= root;
                        path      <= '0;
                        track_len <= '0;
                        state     <= huff_pkg::LEFT;
                    end
                end
                huff_pkg::LEFT, huff_pkg::RIGHT: begin
                    if (child.is_null) begin
                        state <= huff_pkg::FINISH;  // empty block or lone leaf done
                    end else begin
                        path      <= next_path;
                        track_len <= next_len;
                        if (child.is_node) begin
                            cur   <= child.ref_idx;
                            state <= huff_pkg::LEFT;  // always go left first
                        end else begin
                            wr.sym         <= child.ref_idx;
                            wr.entry.valid <= 1'b1;
                            wr.entry.len   <= next_len;
                            wr.entry.bits  <= next_path;
                            wr_en          <= 1'b1;
                            state          <= huff_pkg::SEND;
                        end
                    end
                end
                huff_pkg::SEND: begin
                    if (write_finish) state <= huff_pkg::BACKTRACK;
                end
                huff_pkg::BACKTRACK: begin
                    if (track_len == '0) begin
                        state <= huff_pkg::FINISH;  // both sides of root done
                    end else begin
                        path      <= path >> 1;
                        track_len <= track_len - 4'd1;
                        if (!path[0]) begin
                            cur   <= top;  // parent's right branch is next
                            pos   <= '0;
                            state <= huff_pkg::TRACK;
                        end
                    end
                end
                huff_pkg::TRACK: begin
                    if (pos < track_len) begin
                        cur <= trk_bit ? node.right.ref_idx : node.left.ref_idx;
                        pos <= pos + 4'd1;
                    end else begin
                        state <= huff_pkg::RIGHT;
                    end
                end
                huff_pkg::FINISH: state <= huff_pkg::INIT;
                default:          state <= huff_pkg::INIT;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/huff_histogram.sv */
// counts saturate at 255; symbols and block_end seen while busy is high are dropped
`timescale 1ns/1ps
`default_nettype none

module huff_histogram (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 sym_valid,
    input  wire huff_pkg::sym_t       sym,
    input  wire logic                 block_end,
    input  wire logic                 busy,
    output huff_pkg::freq_table_t     freq,
    output logic                      hist_done
);

    logic accept;  // symbol taken this cycle
    logic close;   // block closed this cycle
    logic fresh;   // next block not started yet, counts are stale

    assign accept = sym_valid && !busy;
    assign close  = block_end && !busy;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            hist_done <= 1'b0;
            fresh     <= 1'b1;  // first block starts from zero
        end else begin
            hist_done <= close;  // one cycle after block_end
            if (close) begin
                fresh <= 1'b1;
            end else if (accept) begin
                fresh <= 1'b0;
            end
        end
    end

    // stale counts are wiped by the first symbol, or by block_end of an empty block
    always_ff @(posedge clk) begin
        if (accept || (close && fresh)) begin
            for (int i = 0; i < huff_pkg::SYM_COUNT; i++) begin
                if (accept && sym == huff_pkg::sym_t'(i)) begin
                    if (fresh) begin
                        freq[i] <= 8'd1;
                    end else if (freq[i] != 8'hff) begin
                        freq[i] <= freq[i] + 8'd1;  // saturate at 255
                    end
                end else if (fresh) begin
                    freq[i] <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/huff_pkg.sv */
// shared widths and types for the 4-bit symbol huffman generator; blocks hold at most 255 symbols
`default_nettype none

package huff_pkg;

    localparam int SYM_COUNT    = 16;  // distinct symbol values
    localparam int MAX_CODE_LEN = 15;  // deepest leaf with 16 symbols

    typedef logic [3:0]  sym_t;        // symbol value
    typedef logic [7:0]  count_t;      // saturating occurrence count
    typedef logic [11:0] weight_t;     // node weight, sum of counts
    typedef logic [3:0]  node_idx_t;   // internal node index, 15 used
    typedef logic [3:0]  code_len_t;   // code length in bits
    typedef logic [MAX_CODE_LEN-1:0] code_bits_t;  // right aligned, first move is msb

    typedef count_t [SYM_COUNT-1:0] freq_table_t;  // 128 bits, entry i is symbol i

    // the field is ref_idx because ref is a reserved word
    typedef struct packed {
        logic      is_node;  // 1: internal node, 0: leaf symbol
        logic      is_null;  // no child here
        logic [3:0] ref_idx; // symbol or node index
    } child_ref_t;

    typedef struct packed {
        weight_t    weight;
        child_ref_t left;    // lighter child, path bit 0
        child_ref_t right;   // heavier child, path bit 1
    } tree_node_t;

    typedef struct packed {
        logic       valid;
        code_len_t  len;
        code_bits_t bits;
    } code_entry_t;

    typedef struct packed {
        sym_t        sym;
        code_entry_t entry;
    } code_wr_t;

    typedef enum logic [2:0] {
        INIT,
        LEFT,
        RIGHT,
        SEND,
        BACKTRACK,
        TRACK,
        FINISH
    } walk_state_t;

    localparam child_ref_t NULL_REF = '{is_node: 1'b0, is_null: 1'b1, ref_idx: 4'd0};

endpackage

`default_nettype wire

/* design/huff_top.sv */
// one block in flight; input while busy is dropped, no handshake and no stream encoding
`timescale 1ns/1ps
`default_nettype none

module huff_top (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             sym_valid,
    input  wire huff_pkg::sym_t   sym,
    input  wire logic             block_end,
    input  wire huff_pkg::sym_t   lookup_sym,
    output huff_pkg::code_entry_t lookup_entry,
    output logic                  book_ready,
    output logic                  busy
);

    huff_pkg::freq_table_t freq;
    huff_pkg::node_idx_t   root, node_addr;
    huff_pkg::tree_node_t  node;
    huff_pkg::code_wr_t    wr;
    logic hist_done, tree_done, walk_done;
    logic wr_en, write_finish;
    logic clear;

    // a new block wipes the old book, an empty block too
    assign clear = book_ready && !busy && (sym_valid || block_end);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (block_end && !busy) begin
            busy <= 1'b1;  // rises with hist_done
        end else if (walk_done) begin
            busy <= 1'b0;  // falls with book_ready rising
        end
    end

    huff_histogram u_hist (
        .clk, .rst, .sym_valid, .sym, .block_end, .busy, .freq, .hist_done
    );

    huff_tree_build u_tree (
        .clk, .rst, .hist_done, .freq, .node_addr, .node, .root, .tree_done
    );

    huff_codebook_walk u_walk (
        .clk, .rst, .tree_done, .root, .node, .write_finish,
        .node_addr, .wr, .wr_en, .walk_done
    );

    huff_code_table u_table (
        .clk, .rst, .wr_en, .wr, .clear, .walk_done, .lookup_sym,
        .lookup_entry, .write_finish, .book_ready
    );

endmodule

`default_nettype wire

/* design/huff_tree_build.sv */
// one scan of 31 candidates per merge, so latency grows with symbol count; freq must hold during build
`timescale 1ns/1ps
`default_nettype none

module huff_tree_build (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  hist_done,
    input  wire huff_pkg::freq_table_t freq,
    input  wire huff_pkg::node_idx_t   node_addr,
    output huff_pkg::tree_node_t       node,
    output huff_pkg::node_idx_t        root,
    output logic                       tree_done
);

    typedef enum logic [1:0] {
        TB_IDLE,
        TB_SCAN,   // one candidate per cycle, leaves 0..15 then nodes 0..14
        TB_MERGE   // write node, or finish
    } build_state_t;

    build_state_t                  state;
    huff_pkg::tree_node_t          node_mem [huff_pkg::SYM_COUNT];
    logic [huff_pkg::SYM_COUNT-1:0] leaf_act;  // leaves still unmerged
    logic [huff_pkg::SYM_COUNT-1:0] node_act;  // internal nodes still unmerged
    huff_pkg::node_idx_t           n_nodes;    // next free node slot
    logic [4:0]                    scan_idx;
    huff_pkg::child_ref_t          l1, l2;     // least and second least
    huff_pkg::weight_t             w1, w2;

    logic                 cand_act;
    huff_pkg::weight_t    cand_w;
    huff_pkg::child_ref_t cand_ref;
    logic                 mem_we;
    huff_pkg::tree_node_t mem_wdata;

    always_comb begin
        cand_ref.is_null = 1'b0;
        cand_ref.is_node = scan_idx[4];
        cand_ref.ref_idx = scan_idx[3:0];
        if (!scan_idx[4]) begin
            cand_act = leaf_act[scan_idx[3:0]];
            cand_w   = huff_pkg::weight_t'(freq[scan_idx[3:0]]);
        end else begin
            cand_act = node_act[scan_idx[3:0]];
            cand_w   = node_mem[scan_idx[3:0]].weight;
        end
    end

    // l2 null means one candidate left: a lone leaf gets a parent, an empty block a null node
    assign mem_we    = (state == TB_MERGE) && (!l2.is_null || !l1.is_node);
    assign mem_wdata = '{weight: w1 + w2, left: l1, right: l2};
    assign node      = node_mem[node_addr];  // same-cycle read for the walker

    always_ff @(posedge clk) begin
        if (mem_we) begin
            node_mem[n_nodes] <= mem_wdata;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state     <= TB_IDLE;
            tree_done <= 1'b0;
            root      <= '0;
        end else begin
            tree_done <= 1'b0;
            case (state)
                TB_IDLE: if (hist_done) state <= TB_SCAN;
                TB_SCAN: if (scan_idx == 5'd30) state <= TB_MERGE;
                TB_MERGE: begin
                    if (l2.is_null) begin
                        root      <= l1.is_node ? l1.ref_idx : n_nodes;  // last node is root
                        tree_done <= 1'b1;
                        state     <= TB_IDLE;
                    end else begin
                        state <= TB_SCAN;
                    end
                end
                default: state <= TB_IDLE;
            endcase
        end
    end

    // scan registers, set up again at every block and every merge
    always_ff @(posedge clk) begin
        if (state == TB_IDLE || state == TB_MERGE) begin
            scan_idx <= '0;
            l1 <= huff_pkg::NULL_REF;
            l2 <= huff_pkg::NULL_REF;
            w1 <= '0;
            w2 <= '0;
        end
        if (state == TB_IDLE && hist_done) begin
            for (int i = 0; i < huff_pkg::SYM_COUNT; i++) begin
                leaf_act[i] <= (freq[i] != '0);
            end
            node_act <= '0;
            n_nodes  <= '0;
        end else if (state == TB_SCAN) begin
            scan_idx <= scan_idx + 5'd1;
            if (cand_act) begin
                if (l1.is_null || cand_w < w1) begin  // strict compare keeps earlier on tie
                    l2 <= l1;
                    w2 <= w1;
                    l1 <= cand_ref;
                    w1 <= cand_w;
                end else if (l2.is_null || cand_w < w2) begin
                    l2 <= cand_ref;
                    w2 <= cand_w;
                end
            end
        end else if (state == TB_MERGE && !l2.is_null) begin
            if (l1.is_node) node_act[l1.ref_idx] <= 1'b0;
            else            leaf_act[l1.ref_idx] <= 1'b0;
            if (l2.is_node) node_act[l2.ref_idx] <= 1'b0;
            else            leaf_act[l2.ref_idx] <= 1'b0;
            node_act[n_nodes] <= 1'b1;  // new node joins the candidates
            n_nodes <= n_nodes + 4'd1;
        end
    end

endmodule

`default_nettype wire

/* files.f */
design/huff_pkg.sv
design/huff_histogram.sv
design/huff_tree_build.sv
design/huff_codebook_walk.sv
design/huff_code_table.sv
design/huff_top.sv
verif/huff_asserts.sv
verif/huff_tb.sv

/* verif/huff_asserts.sv */
// bound into huff_top; checks pulse widths, the write ack and the busy and lookup outputs
`timescale 1ns/1ps
`default_nettype none

module huff_asserts (
    input wire logic                  clk,
    input wire logic                  rst,
    input wire logic                  hist_done,
    input wire logic                  walk_done,
    input wire logic                  wr_en,
    input wire logic                  write_finish,
    input wire logic                  busy,
    input wire logic                  book_ready,
    input wire huff_pkg::code_entry_t lookup_entry
);

    hist_pulse: assert property (@(posedge clk) disable iff (rst) hist_done |=> !hist_done)
        else $error("hist_done high for more than one cycle");

    walk_pulse: assert property (@(posedge clk) disable iff (rst)
        walk_done |=> !walk_done && book_ready)
        else $error("walk_done not a single pulse or book_ready not raised after it");

    ack_follows: assert property (@(posedge clk) disable iff (rst)
        wr_en |=> write_finish && !wr_en)
        else $error("write_finish missing after wr_en, or a second write before it");

    ready_idle: assert property (@(posedge clk) disable iff (rst) book_ready |-> !busy)
        else $error("busy high while book_ready is high");

    valid_len: assert property (@(posedge clk) disable iff (rst)
        lookup_entry.valid |-> lookup_entry.len != '0)
        else $error("valid code entry with zero length");

endmodule

bind huff_top huff_asserts u_asserts (
    .clk, .rst, .hist_done, .walk_done, .wr_en, .write_finish, .busy, .book_ready, .lookup_entry
);

`default_nettype wire

/* verif/huff_tb.sv */
// directed and random blocks below 255 symbols; random codes checked by cost, prefix and kraft, exact bits only for the tie block
`timescale 1ns/1ps
`default_nettype none

module huff_tb;

    localparam int N_RANDOM    = 6;
    localparam int N_BLOCKS    = N_RANDOM + 5;          // tie, single, empty, two busy blocks
    localparam int WATCHDOG_NS = N_BLOCKS * 40000 * 20;  // 40k cycles of 20 ns per block

    logic                  clk;
    logic                  rst;
    logic                  sym_valid;
    huff_pkg::sym_t        sym;
    logic                  block_end;
    huff_pkg::sym_t        lookup_sym;
    huff_pkg::code_entry_t lookup_entry;
    logic                  book_ready;
    logic                  busy;

    int                    cnt [huff_pkg::SYM_COUNT];   // accepted symbols of the current block
    huff_pkg::code_entry_t book [huff_pkg::SYM_COUNT];  // table as read back

    huff_top uut (
        .clk, .rst, .sym_valid, .sym, .block_end, .lookup_sym,
        .lookup_entry, .book_ready, .busy
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_entry(input string name, input huff_pkg::code_entry_t exp,
                               input huff_pkg::code_entry_t act);
        if (act !== exp) begin
            fail_run($sformatf(
                "FAIL %s expected v=%0d len=%0d bits=%b actual v=%0d len=%0d bits=%b",
                name, exp.valid, exp.len, exp.bits, act.valid, act.len, act.bits));
        end
    endtask

    task automatic check_cost(input string name, input huff_pkg::weight_t exp,
                              input huff_pkg::weight_t act);
        if (act !== exp) begin
            fail_run($sformatf("FAIL %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("FAIL %s expected %0b actual %0b", name, exp, act));
        end
    endtask

    // optimal total code bits: sum of every merged weight, independent of ties
    function automatic huff_pkg::weight_t huffman_cost(input int counts [huff_pkg::SYM_COUNT]);
        int w [$];
        int a;
        int b;
        int total;
        total = 0;
        foreach (counts[i]) begin
            if (counts[i] > 0) w.push_back(counts[i]);
        end
        if (w.size() == 1) return huff_pkg::weight_t'(w[0]);  // lone symbol costs one bit each
        while (w.size() > 1) begin
            w.sort();
            a = w.pop_front();
            b = w.pop_front();
            total += a + b;
            w.push_back(a + b);
        end
        return huff_pkg::weight_t'(total);
    endfunction

    function automatic huff_pkg::code_entry_t make_code(input int len, input int bits);
        huff_pkg::code_entry_t e;
        e.valid = 1'b1;
        e.len   = huff_pkg::code_len_t'(len);
        e.bits  = huff_pkg::code_bits_t'(bits);
        return e;
    endfunction

    // busy is low here, so every driven symbol is counted
    task automatic send_block(input huff_pkg::sym_t syms [$]);
        foreach (cnt[i]) cnt[i] = 0;
        foreach (syms[i]) begin
            @(negedge clk);
            sym_valid = 1'b1;
            sym       = syms[i];
            cnt[syms[i]]++;
        end
        @(negedge clk);
        sym_valid = 1'b0;
        block_end = 1'b1;
        @(negedge clk);
        block_end = 1'b0;
        check_flag("busy after block_end", 1'b1, busy);  // rises with hist_done
        check_flag("book_ready in a new block", 1'b0, book_ready);
    endtask

    task automatic drive_while_busy(input int n);
        repeat (n) begin
            @(negedge clk);
            if (!book_ready) begin
                check_flag("busy during the build", 1'b1, busy);
            end
            sym_valid = !book_ready;  // symbol 15 never occurs in the busy blocks
            sym       = 4'hf;
        end
        @(negedge clk);
        sym_valid = 1'b0;
    endtask

    task automatic wait_book();
        while (!book_ready) @(negedge clk);
        check_flag("busy with book_ready", 1'b0, busy);
    endtask

    task automatic verify_book(input string name);
        int cost;
        int kraft;
        int n_sym;
        cost  = 0;
        kraft = 0;
        n_sym = 0;
        for (int s = 0; s < huff_pkg::SYM_COUNT; s++) begin
            @(negedge clk);
            lookup_sym = huff_pkg::sym_t'(s);
            #5;
            book[s] = lookup_entry;  // read away from the clock edges
        end
        for (int s = 0; s < huff_pkg::SYM_COUNT; s++) begin
            if (cnt[s] == 0) begin
                check_entry($sformatf("%s absent sym %0d", name, s), '0, book[s]);
            end else begin
                if (!book[s].valid) begin
                    fail_run($sformatf("%s: symbol %0d occurs but has no code", name, s));
                end
                cost  += cnt[s] * int'(book[s].len);
                kraft += 1 << (huff_pkg::MAX_CODE_LEN - int'(book[s].len));
                n_sym++;
            end
        end
        check_cost($sformatf("%s cost", name), huffman_cost(cnt), huff_pkg::weight_t'(cost));
        if (n_sym >= 2 && kraft != (1 << huff_pkg::MAX_CODE_LEN)) begin
            fail_run($sformatf("%s: code lengths do not fill the tree, kraft sum %0d", name, kraft));
        end
        for (int i = 0; i < huff_pkg::SYM_COUNT; i++) begin
            for (int j = 0; j < huff_pkg::SYM_COUNT; j++) begin
                if (i != j && book[i].valid && book[j].valid && book[i].len <= book[j].len &&
                    (book[j].bits >> (book[j].len - book[i].len)) == book[i].bits) begin
                    fail_run($sformatf("%s: code of symbol %0d is a prefix of symbol %0d",
                                       name, i, j));
                end
            end
        end
    endtask

    initial begin
        huff_pkg::sym_t q [$];
        huff_pkg::sym_t none [$];
        int n;
        int hi;
        void'($urandom(32'h4e21));
        rst        = 1'b1;
        sym_valid  = 1'b0;
        sym        = '0;
        block_end  = 1'b0;
        lookup_sym = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        check_flag("busy after reset", 1'b0, busy);
        check_flag("book_ready after reset", 1'b0, book_ready);

        q = {4'd0, 4'd1, 4'd2, 4'd2, 4'd3, 4'd3, 4'd3, 4'd3};  // counts 1 1 2 4
        send_block(q);
        wait_book();
        verify_book("tie block");
        check_entry("tie block sym 0", make_code(3, 'b110), book[0]);
        check_entry("tie block sym 1", make_code(3, 'b111), book[1]);
        check_entry("tie block sym 2", make_code(2, 'b10), book[2]);
        check_entry("tie block sym 3", make_code(1, 'b0), book[3]);

        q = {4'd9, 4'd9, 4'd9, 4'd9, 4'd9};
        send_block(q);
        wait_book();
        verify_book("single block");
        check_entry("single block sym 9", make_code(1, 0), book[9]);

        send_block(none);
        wait_book();
        verify_book("empty block");  // every entry must read invalid

        q = {4'd3, 4'd3, 4'd3, 4'd5, 4'd5, 4'd7, 4'd1, 4'd1, 4'd1, 4'd1};
        send_block(q);
        drive_while_busy(20);
        wait_book();
        verify_book("busy block a");
        q = {4'd2, 4'd4, 4'd4, 4'd6, 4'd6, 4'd6};
        send_block(q);
        wait_book();
        verify_book("busy block b");

        for (int b = 0; b < N_RANDOM; b++) begin
            q.delete();
            n  = $urandom_range(2, 200);
            hi = $urandom_range(1, 15);
            for (int k = 0; k < n; k++) begin
                q.push_back(huff_pkg::sym_t'($urandom_range(0, $urandom_range(0, hi))));  // skewed
            end
            send_block(q);
            wait_book();
            verify_book($sformatf("random block %0d", b));
        end

        $display("Test completed successfully");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run("timeout: the design did not finish all blocks in time");
    end

endmodule

`default_nettype wire
